// File: Bender.yml
package:
  name: rv32_front

sources:
  - logic/coreDefsPkg.sv
  - logic/fetchLink.sv
  - logic/issueLink.sv
  - logic/fetchUnit.sv
  - logic/ifidStageReg.sv
  - logic/execUnit.sv
  - logic/rv32Front.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/rv32FrontTb.sv

// File: files.f
+incdir+verif
logic/coreDefsPkg.sv
logic/fetchLink.sv
logic/issueLink.sv
logic/fetchUnit.sv
logic/ifidStageReg.sv
logic/execUnit.sv
logic/rv32Front.sv
verif/rv32FrontTb.sv

// File: logic/coreDefsPkg.sv
// core definitions shared by the fetch, stage-register and execute blocks
package coreDefsPkg;

    // data, instruction and address words
    typedef logic [31:0] wordT;

    // architectural register index
    typedef logic [4:0] regIdxT;

    // RV32I major opcodes handled by the execute unit
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeT;

    // ALU operations
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSlt   = 4'd5,
        aluSll   = 4'd6,
        aluSrl   = 4'd7,
        aluPassB = 4'd8  // operand b straight through, used by LUI
    } aluOpT;

    // funct3 encodings for the branches covered here
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;
    localparam logic [2:0] f3Blt = 3'b100;
    localparam logic [2:0] f3Bge = 3'b101;

    // funct3 encodings shared by register and immediate ALU ops
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Srl    = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // ADDI x0,x0,0
    localparam wordT nopInst = 32'h00000013;

endpackage

// File: logic/execUnit.sv
// execute unit: decode, register file, ALU, branch resolve and retire report
`timescale 1ns/1ps

module execUnit (
    input  logic               clk,
    input  logic               reset,
    issueLink.exec             link,
    output logic               retireValid,
    output coreDefsPkg::wordT  retirePc,
    output coreDefsPkg::regIdxT retireRd,
    output coreDefsPkg::wordT  retireData
);
    import coreDefsPkg::*;

    wordT   regFile [32];
    opcodeT opcode;
    regIdxT rd;
    regIdxT rs1;
    regIdxT rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    wordT   immI;
    wordT   immU;
    wordT   immB;
    wordT   immJ;
    wordT   rs1Val;
    wordT   rs2Val;
    wordT   opB;
    wordT   aluResult;
    wordT   result;
    aluOpT  aluOp;
    logic   regWrite;
    logic   isBranch;
    logic   isJal;
    logic   branchTaken;

    // instruction fields
    assign opcode = opcodeT'(link.inst[6:0]);
    assign rd     = link.inst[11:7];
    assign funct3 = link.inst[14:12];
    assign rs1    = link.inst[19:15];
    assign rs2    = link.inst[24:20];
    assign funct7 = link.inst[31:25];

    assign immI = {{20{link.inst[31]}}, link.inst[31:20]};
    assign immU = {link.inst[31:12], 12'b0};
    assign immB = {{19{link.inst[31]}}, link.inst[31], link.inst[7],
                   link.inst[30:25], link.inst[11:8], 1'b0};
    assign immJ = {{11{link.inst[31]}}, link.inst[31], link.inst[19:12],
                   link.inst[20], link.inst[30:21], 1'b0};

    // x0 reads as zero
    assign rs1Val = (rs1 == '0) ? '0 : regFile[rs1];
    assign rs2Val = (rs2 == '0) ? '0 : regFile[rs2];

    always_comb begin
        aluOp    = aluAdd;
        opB      = rs2Val;
        regWrite = 1'b0;
        isBranch = 1'b0;
        isJal    = 1'b0;
        case (opcode)
            opReg: begin
                regWrite = 1'b1;
                case (funct3)
                    f3AddSub: aluOp = funct7[5] ? aluSub : aluAdd;
                    f3Sll:    aluOp = aluSll;
                    f3Slt:    aluOp = aluSlt;
                    f3Xor:    aluOp = aluXor;
                    f3Srl:    aluOp = aluSrl;
                    f3Or:     aluOp = aluOr;
                    f3And:    aluOp = aluAnd;
                    default:  regWrite = 1'b0;  // SLTU not handled
                endcase
            end
            opImm: begin
                opB      = immI;
                regWrite = 1'b1;
                case (funct3)
                    f3AddSub: aluOp = aluAdd;
                    f3Slt:    aluOp = aluSlt;
                    f3Xor:    aluOp = aluXor;
                    f3Or:     aluOp = aluOr;
                    f3And:    aluOp = aluAnd;
                    default:  regWrite = 1'b0;  // immediate shifts, SLTIU
                endcase
            end
            opLui: begin
                aluOp    = aluPassB;
                opB      = immU;
                regWrite = 1'b1;
            end
            opBranch: isBranch = 1'b1;
            opJal: begin
                isJal    = 1'b1;
                regWrite = 1'b1;
            end
            default: ;  // retires with no write
        endcase
    end

    always_comb begin
        case (aluOp)
            aluAdd:   aluResult = rs1Val + opB;
            aluSub:   aluResult = rs1Val - opB;
            aluAnd:   aluResult = rs1Val & opB;
            aluOr:    aluResult = rs1Val | opB;
            aluXor:   aluResult = rs1Val ^ opB;
            aluSlt:   aluResult = {31'b0, $signed(rs1Val) < $signed(opB)};
            aluSll:   aluResult = rs1Val << opB[4:0];
            aluSrl:   aluResult = rs1Val >> opB[4:0];
            aluPassB: aluResult = opB;
            default:  aluResult = '0;
        endcase
    end

    always_comb begin
        case (funct3)
            f3Beq:   branchTaken = (rs1Val == rs2Val);
            f3Bne:   branchTaken = (rs1Val != rs2Val);
            f3Blt:   branchTaken = $signed(rs1Val) < $signed(rs2Val);
            f3Bge:   branchTaken = $signed(rs1Val) >= $signed(rs2Val);
            default: branchTaken = 1'b0;
        endcase
    end

    assign result = isJal ? link.pc + 32'd4 : aluResult;  // link address for JAL

    assign link.flush      = link.issueValid && (isJal || (isBranch && branchTaken));
    assign link.redirectPc = link.pc + (isJal ? immJ : immB);

    assign retireValid = link.issueValid;
    assign retirePc    = link.pc;
    assign retireRd    = regWrite ? rd : '0;
    assign retireData  = regWrite ? result : '0;

    // architectural state starts at zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
        end else if (link.issueValid && regWrite && rd != '0) begin
            regFile[rd] <= result;
        end
    end

endmodule

// File: logic/fetchLink.sv
// fetch link: fetched pc/instruction toward IF/ID, stall back to fetch
`timescale 1ns/1ps

interface fetchLink;
    import coreDefsPkg::*;

    wordT pc;          // address of inst
    wordT inst;
    logic fetchValid;
    logic stall;       // IF/ID not taking new words

    modport fetch (
        output pc,
        output inst,
        output fetchValid,
        input  stall
    );

    modport stage (
        input  pc,
        input  inst,
        input  fetchValid,
        output stall
    );

endinterface

// File: logic/fetchUnit.sv
// fetch unit holding the program counter, next-pc select and instruction memory address
`timescale 1ns/1ps

module fetchUnit #(
    parameter coreDefsPkg::wordT resetPc = '0
) (
    input  logic              clk,
    input  logic              reset,
    output coreDefsPkg::wordT instAddr,
    input  coreDefsPkg::wordT instData,
    fetchLink.fetch           link,
    issueLink.redirect        redir
);
    import coreDefsPkg::*;

    wordT pcReg;
    wordT pcNext;

    // redirect wins over stall
    always_comb begin
        if (redir.flush) begin
            pcNext = redir.redirectPc;
        end else if (!link.stall) begin
            pcNext = pcReg + 32'd4;
        end else begin
            pcNext = pcReg;  // frozen
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pcReg <= resetPc;
        end else begin
            pcReg <= pcNext;
        end
    end

    assign instAddr = pcReg;

    // memory is read combinationally at instAddr
    assign link.pc         = pcReg;
    assign link.inst       = instData;
    assign link.fetchValid = !reset;  // real words as soon as reset is gone

endmodule

// File: logic/ifidStageReg.sv
// IF/ID stage register with stall freeze, flush to NOP and one-cycle valid
`timescale 1ns/1ps

module ifidStageReg (
    input  logic    clk,
    input  logic    reset,
    input  logic    hold,
    fetchLink.stage inLink,
    issueLink.stage outLink
);
    import coreDefsPkg::*;

    logic capture;

    // a flush overrides hold, so fetch is never stalled on a redirect
    assign inLink.stall = hold && !outLink.flush;

    assign capture = inLink.fetchValid && !hold;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outLink.inst       <= nopInst;
            outLink.pc         <= '0;
            outLink.issueValid <= 1'b0;
        end else if (outLink.flush) begin
            // wrong-path word replaced by a bubble
            outLink.inst       <= nopInst;
            outLink.pc         <= inLink.pc;
            outLink.issueValid <= 1'b0;
        end else if (capture) begin
            outLink.inst       <= inLink.inst;
            outLink.pc         <= inLink.pc;
            outLink.issueValid <= 1'b1;
        end else begin
            outLink.issueValid <= 1'b0;  // contents stay, pulse ends
        end
    end

endmodule

// File: logic/issueLink.sv
// issue link: held instruction toward execute, redirect back to fetch and IF/ID
`timescale 1ns/1ps

interface issueLink;
    import coreDefsPkg::*;

    wordT pc;
    wordT inst;
    logic issueValid;  // one cycle per captured instruction
    logic flush;
    wordT redirectPc;

    modport stage (
        output pc,
        output inst,
        output issueValid,
        input  flush
    );

    modport exec (
        input  pc,
        input  inst,
        input  issueValid,
        output flush,
        output redirectPc
    );

    // fetch side only needs the redirect
    modport redirect (
        input flush,
        input redirectPc
    );

endinterface

// File: logic/rv32Front.sv
// RV32I front: fetch unit, IF/ID register and execute unit joined together
`timescale 1ns/1ps

module rv32Front #(
    parameter coreDefsPkg::wordT resetPc = '0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                hold,         // back-pressure into IF/ID
    input  coreDefsPkg::wordT   instData,
    output coreDefsPkg::wordT   instAddr,
    output logic                retireValid,
    output coreDefsPkg::wordT   retirePc,
    output coreDefsPkg::regIdxT retireRd,
    output coreDefsPkg::wordT   retireData
);

    fetchLink fLink ();
    issueLink iLink ();

    fetchUnit #(
        .resetPc (resetPc)
    ) uFetch (
        .clk      (clk),
        .reset    (reset),
        .instAddr (instAddr),
        .instData (instData),
        .link     (fLink.fetch),
        .redir    (iLink.redirect)
    );

    ifidStageReg uIfid (
        .clk     (clk),
        .reset   (reset),
        .hold    (hold),
        .inLink  (fLink.stage),
        .outLink (iLink.stage)
    );

    execUnit uExec (
        .clk         (clk),
        .reset       (reset),
        .link        (iLink.exec),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

endmodule

// File: verif/tbProgram.svh
// test program for the RV32I front and the pc order in which it must retire
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int   progLen  = 30;
localparam int   orderLen = 28;
localparam wordT endPc    = 32'h000000b4;  // jal x0,0 spin at the end

// loaded at 0x40
localparam wordT progImage [progLen] = '{
    32'h00500093,  // 40 addi x1, x0, 5
    32'hffd00113,  // 44 addi x2, x0, -3
    32'h002081b3,  // 48 add  x3, x1, x2
    32'h40208233,  // 4c sub  x4, x1, x2
    32'h0020f2b3,  // 50 and  x5, x1, x2
    32'h0020e333,  // 54 or   x6, x1, x2
    32'h0020c3b3,  // 58 xor  x7, x1, x2
    32'h00112433,  // 5c slt  x8, x2, x1
    32'h003094b3,  // 60 sll  x9, x1, x3
    32'h00315533,  // 64 srl  x10, x2, x3
    32'h123455b7,  // 68 lui  x11, 0x12345
    32'h6785e593,  // 6c ori  x11, x11, 0x678
    32'hfff5c613,  // 70 xori x12, x11, -1
    32'h0ff5f693,  // 74 andi x13, x11, 0xff
    32'hffe12713,  // 78 slti x14, x2, -2
    32'h00708013,  // 7c addi x0, x1, 7
    32'h001007b3,  // 80 add  x15, x0, x1
    32'h00f08463,  // 84 beq  x1, x15, +8   taken
    32'h06300813,  // 88 addi x16, x0, 99   wrong path
    32'h00109463,  // 8c bne  x1, x1, +8    not taken
    32'h00114463,  // 90 blt  x2, x1, +8    taken
    32'h06200813,  // 94 addi x16, x0, 98   wrong path
    32'h00115463,  // 98 bge  x2, x1, +8    not taken
    32'h0020d463,  // 9c bge  x1, x2, +8    taken
    32'h06100813,  // a0 addi x16, x0, 97   wrong path
    32'h008008ef,  // a4 jal  x17, +8
    32'h06000813,  // a8 addi x16, x0, 96   wrong path
    32'h00198993,  // ac addi x19, x19, 1
    32'hfe399ee3,  // b0 bne  x19, x3, -4   taken once
    32'h0000006f   // b4 jal  x0, 0
};

// wrong-path words never show up here
localparam wordT retireOrder [orderLen] = '{
    32'h040, 32'h044, 32'h048, 32'h04c, 32'h050, 32'h054,
    32'h058, 32'h05c, 32'h060, 32'h064, 32'h068, 32'h06c,
    32'h070, 32'h074, 32'h078, 32'h07c, 32'h080, 32'h084,
    32'h08c, 32'h090, 32'h098, 32'h09c, 32'h0a4, 32'h0ac,
    32'h0b0, 32'h0ac, 32'h0b0, 32'h0b4
};

`endif

// File: verif/rv32FrontTb.sv
// testbench for the RV32I front with reference model, retire checks and random hold
`timescale 1ns/1ps

module rv32FrontTb;
    import coreDefsPkg::*;

    localparam wordT bootPc    = 32'h00000040;
    localparam int   waitLimit = 500;

    logic   clk;
    logic   reset;
    logic   hold;
    logic   retireValid;
    wordT   instData, instAddr, retirePc, retireData;
    regIdxT retireRd;

    wordT   imem [64];
    wordT   regs [32];  // model register file with x0 never written
    wordT   expPc, expNextPc, expData, mInst, opA, opB;
    regIdxT expRd;
    logic   expWrites;
    logic   holdEnable;
    int     retired;
    int     errors;
    int     tests;
    integer seed;

    `include "tbProgram.svh"

    rv32Front #(.resetPc(bootPc)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign instData = imem[instAddr[7:2]];  // combinational fetch

    // bit 30 picks SUB on register ops
    function automatic wordT aluRef(input logic [2:0] f3, input logic sub,
                                    input wordT a, input wordT b);
        case (f3)
            3'd0:    return sub ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic takenRef(input logic [2:0] f3, input wordT a, input wordT b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    // expected outcome of the instruction at expPc
    assign mInst = imem[expPc[7:2]];
    assign opA   = regs[mInst[19:15]];
    assign opB   = regs[mInst[24:20]];

    always_comb begin
        expWrites = 1'b0;
        expData   = '0;
        expNextPc = expPc + 32'd4;
        case (mInst[6:0])
            7'h33: begin
                expWrites = 1'b1;
                expData   = aluRef(mInst[14:12], mInst[30], opA, opB);
            end
            7'h13: begin
                expWrites = 1'b1;
                expData   = aluRef(mInst[14:12], 1'b0, opA, {{20{mInst[31]}}, mInst[31:20]});
            end
            7'h37: begin
                expWrites = 1'b1;
                expData   = {mInst[31:12], 12'h000};
            end
            7'h63: begin
                if (takenRef(mInst[14:12], opA, opB)) begin
                    expNextPc = expPc + {{20{mInst[31]}}, mInst[7], mInst[30:25],
                                         mInst[11:8], 1'b0};
                end
            end
            7'h6f: begin
                expWrites = 1'b1;
                expData   = expPc + 32'd4;  // link address
                expNextPc = expPc + {{12{mInst[31]}}, mInst[19:12], mInst[20],
                                     mInst[30:21], 1'b0};
            end
            default: ;
        endcase
        expRd = expWrites ? mInst[11:7] : 5'd0;
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            expPc   <= bootPc;
            retired <= 0;
        end else if (retireValid) begin
            if (expRd != 5'd0) begin
                regs[expRd] <= expData;
            end
            expPc   <= expNextPc;
            retired <= retired + 1;
        end
    end

    task automatic reportMismatch(input string name, input wordT expected, input wordT actual);
        errors++;
        $display("[ERROR] %s expected %h got %h", name, expected, actual);
    endtask

    // reset state and the first cycle after it
    assert property (@(posedge clk) (reset || $past(reset)) |-> !retireValid)
        else reportMismatch("retireValid", 0, $sampled(retireValid));
    assert property (@(posedge clk) (reset || $past(reset)) |-> instAddr == bootPc)
        else reportMismatch("instAddr", bootPc, $sampled(instAddr));

    // word at the reset pc is taken at the first edge and retires in the cycle after
    assert property (@(posedge clk) disable iff (reset)
                     $past(reset, 2) && !$past(reset) |-> retireValid)
        else reportMismatch("retireValid", 1, $sampled(retireValid));

    assert property (@(posedge clk) disable iff (reset) retireValid |-> retirePc == expPc)
        else reportMismatch("retirePc", $sampled(expPc), $sampled(retirePc));
    assert property (@(posedge clk) disable iff (reset) retireValid |-> retireRd == expRd)
        else reportMismatch("retireRd", $sampled(expRd), $sampled(retireRd));
    assert property (@(posedge clk) disable iff (reset)
                     retireValid && expWrites |-> retireData == expData)
        else reportMismatch("retireData", $sampled(expData), $sampled(retireData));
    assert property (@(posedge clk) disable iff (reset)
                     retireValid && retired < orderLen |-> retirePc == retireOrder[retired])
        else reportMismatch("retirePc", retireOrder[$sampled(retired)], $sampled(retirePc));

    // only the first held cycle may retire
    assert property (@(posedge clk) disable iff (reset) hold && $past(hold) |-> !retireValid)
        else reportMismatch("retireValid", 0, $sampled(retireValid));

    always @(posedge clk) begin
        if (holdEnable) begin
            hold <= ($random(seed) & 3) == 0;  // about one cycle in four
        end else begin
            hold <= 1'b0;
        end
    end

    task automatic applyReset();
        reset <= 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic waitRetire(input wordT pc, input string what);
        int  cycles;
        bit  seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < waitLimit) begin
            @(negedge clk);
            seen = retireValid && retirePc == pc;
            cycles++;
        end
        if (!seen) begin
            errors++;
            $display("timeout waiting for %s: no retire at pc %h in %0d cycles",
                     what, pc, cycles);
        end
    endtask

    task automatic reportTest(input string name);
        tests++;
        $display("test %s finished: %0d retired, %0d errors so far", name, retired, errors);
    endtask

    initial begin
        reset      = 1'b0;
        hold       = 1'b0;
        holdEnable = 1'b0;
        errors     = 0;
        tests      = 0;
        seed       = 32'hf72451a8;
        for (int i = 0; i < 64; i++) begin
            imem[i] = {25'(i), 7'b0001011};  // custom-0 opcode tagged with its index
        end
        for (int i = 0; i < progLen; i++) begin
            imem[bootPc[7:2] + i] = progImage[i];
        end

        applyReset();
        waitRetire(bootPc, "first retire after reset");
        reportTest("reset");
        waitRetire(endPc, "end of program");
        reportTest("program");

        // same program again under random back-pressure
        @(posedge clk);
        applyReset();
        holdEnable <= 1'b1;
        waitRetire(endPc, "end of program under hold");
        holdEnable <= 1'b0;
        reportTest("hold");

        repeat (4) @(posedge clk);
        $display("%0d tests run, %0d retired in last run, %0d errors", tests, retired, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
